/* verilog/sysPkg.sv */
package sysPkg;

    // RAM geometry
    localparam int ramAddrBits = 10;
    localparam int ramWords = 1024;

    typedef logic [31:0] wordT;
    typedef logic [31:0] addrT;
    typedef logic [ramAddrBits-1:0] ramAddrT;
    typedef logic [7:0] ioCodeT;
    typedef logic [7:0] ledT;
    // Buttons 1..6 on bits 0..5
    typedef logic [5:0] buttonsT;

    // Top address byte of an I/O access
    localparam ioCodeT ioLoadButtons = 8'd1;
    localparam ioCodeT ioWriteLeds0 = 8'd2;
    localparam ioCodeT ioWriteLeds1 = 8'd3;
    localparam ioCodeT ioWriteLeds2 = 8'd4;
    localparam ioCodeT ioWriteLeds3 = 8'd5;

    // Boot phase patterns
    localparam ledT ledReset = 8'b0010_0100;
    localparam ledT ledSizeLoad = 8'b0100_1001;
    localparam ledT ledSizeWait = 8'b0110_1101;
    localparam ledT ledRamLoad = 8'b1001_0010;

    localparam int resetDelayCycles = 16;
    // Card reader loses requests that arrive too close together
    localparam int sdPaceCycles = 32;
    localparam int buttonHoldCycles = 64;

    typedef logic [$clog2(resetDelayCycles + 1)-1:0] resetCountT;
    typedef logic [$clog2(sdPaceCycles)-1:0] paceCountT;
    typedef logic [$clog2(buttonHoldCycles + 1)-1:0] holdCountT;

    typedef enum logic [2:0] {
        stReset,
        stSizeLoad,
        stSizeWait,
        stRamLoad,
        stLoadDone,
        stRun
    } bootStateT;

    typedef struct packed {
        logic instrRead;
        addrT instrAddr;
        logic dataRead;
        logic dataWrite;
        addrT dataAddr;
        wordT writeData;
    } cpuReqT;

    typedef struct packed {
        wordT instruction;
        logic instrLoaded;
        wordT readData;
        logic dataLoaded;
        logic dataStored;
    } cpuRespT;

    typedef struct packed {
        logic read;
        addrT address;
    } sdReqT;

    typedef struct packed {
        logic busy;
        wordT data;
    } sdRespT;

    typedef struct packed {
        logic readEn;
        logic writeEn;
        ramAddrT addr;
        wordT writeData;
    } ramPortT;

    typedef struct packed {
        logic write;
        ioCodeT code;
        wordT writeData;
    } ioAccessT;

endpackage

/* verilog/wordRam.sv */
module wordRam (
    input  logic            CPUClock,
    input  sysPkg::ramPortT port,
    output sysPkg::wordT    readData,
    output logic            dataReady,
    output logic            dataWritten
);

    sysPkg::wordT mem [sysPkg::ramWords];

    // Strobes follow the sampled request by one cycle
    always_ff @(posedge CPUClock) begin
        dataReady <= port.readEn;
        dataWritten <= port.writeEn;
    end

    always_ff @(posedge CPUClock) begin
        if (port.writeEn) begin
            mem[port.addr] <= port.writeData;
        end
        if (port.readEn) begin
            readData <= mem[port.addr];
        end
    end

endmodule

/* verilog/bootLoader.sv */
module bootLoader (
    input  logic              CPUClock,
    input  logic              rstN,
    input  logic              runButton,
    output sysPkg::sdReqT     sdReq,
    input  sysPkg::sdRespT    sdResp,
    output sysPkg::ramPortT   loadPort,
    output sysPkg::bootStateT bootState,
    output logic              cpuReset
);

    sysPkg::resetCountT resetCount;
    sysPkg::paceCountT paceCount;
    logic resetDone;
    logic paceDone;
    logic sdReady;

    logic sdRead;
    sysPkg::addrT sdAddr;
    sysPkg::wordT wordCount;

    logic loadWrite;
    sysPkg::ramAddrT loadAddr;
    sysPkg::wordT loadData;

    assign resetDone = resetCount == sysPkg::resetCountT'(sysPkg::resetDelayCycles);
    assign paceDone = paceCount == sysPkg::paceCountT'(sysPkg::sdPaceCycles - 1);
    // Paced and reader idle, so a new request may go out or data can be taken
    assign sdReady = paceDone && !sdResp.busy;

    assign sdReq = '{read: sdRead, address: sdAddr};

    assign loadPort = '{readEn: 1'b0, writeEn: loadWrite, addr: loadAddr, writeData: loadData};

    // Processor also held while the run button is released
    assign cpuReset = (bootState != sysPkg::stRun) || !runButton;

    always_ff @(posedge CPUClock) begin
        if (!rstN) begin
            bootState <= sysPkg::stReset;
            resetCount <= '0;
            paceCount <= '0;
            sdRead <= 1'b0;
            sdAddr <= '0;
            loadWrite <= 1'b0;
        end else begin
            sdRead <= 1'b0;
            loadWrite <= 1'b0;
            // Pacing only advances while the reader is idle
            if (!sdResp.busy && !paceDone) begin
                paceCount <= paceCount + 1'b1;
            end

            case (bootState)
                sysPkg::stReset: begin
                    paceCount <= '0;
                    sdAddr <= '0;
                    if (!resetDone) begin
                        resetCount <= resetCount + 1'b1;
                    end else if (runButton) begin
                        bootState <= sysPkg::stSizeLoad;
                    end
                end
                sysPkg::stSizeLoad: begin
                    // Word 0 holds the image length
                    if (sdReady) begin
                        sdRead <= 1'b1;
                        sdAddr <= '0;
                        paceCount <= '0;
                        bootState <= sysPkg::stSizeWait;
                    end
                end
                sysPkg::stSizeWait: begin
                    if (sdReady) begin
                        wordCount <= sdResp.data;
                        if (sdResp.data == '0) begin
                            bootState <= sysPkg::stRun;
                        end else begin
                            sdRead <= 1'b1;
                            sdAddr <= sysPkg::addrT'(1);
                            paceCount <= '0;
                            bootState <= sysPkg::stRamLoad;
                        end
                    end
                end
                sysPkg::stRamLoad: begin
                    if (sdReady) begin
                        // SD word k lands in RAM word k-1
                        loadWrite <= 1'b1;
                        loadAddr <= sysPkg::ramAddrT'(sdAddr - 1'b1);
                        loadData <= sdResp.data;
                        if (sdAddr == wordCount) begin
                            bootState <= sysPkg::stLoadDone;
                        end else begin
                            sdRead <= 1'b1;
                            sdAddr <= sdAddr + 1'b1;
                            paceCount <= '0;
                        end
                    end
                end
                sysPkg::stLoadDone: begin
                    bootState <= sysPkg::stRun;
                end
                sysPkg::stRun: begin
                    if (!runButton) begin
                        resetCount <= '0;
                        bootState <= sysPkg::stReset;
                    end
                end
                default: begin
                    bootState <= sysPkg::stReset;
                end
            endcase
        end
    end

endmodule

/* verilog/busRouter.sv */
module busRouter (
    input  sysPkg::bootStateT bootState,
    input  sysPkg::ramPortT   loadPort,
    input  sysPkg::cpuReqT    cpuReq,
    output sysPkg::cpuRespT   cpuResp,
    output sysPkg::ramPortT   ramPort,
    input  sysPkg::wordT      ramReadData,
    input  logic              ramReady,
    input  logic              ramWritten,
    output sysPkg::ioAccessT  ioAccess,
    input  sysPkg::buttonsT   buttons
);

    logic running;
    sysPkg::ioCodeT ioCode;
    logic isIo;
    logic ramBusy;
    logic dataOnRam;

    assign running = bootState == sysPkg::stRun;
    assign ioCode = cpuReq.dataAddr[31:24];
    assign isIo = ioCode != '0;
    // No new RAM access in the strobe cycle of the previous one
    assign ramBusy = ramReady || ramWritten;
    assign dataOnRam = !cpuReq.instrRead && !isIo;

    always_comb begin
        if (!running) begin
            ramPort = loadPort;
        end else begin
            ramPort.readEn = !ramBusy && (cpuReq.instrRead || (cpuReq.dataRead && !isIo));
            ramPort.writeEn = !ramBusy && dataOnRam && cpuReq.dataWrite;
            // Instruction fetch wins the port
            ramPort.addr = cpuReq.instrRead ? cpuReq.instrAddr[sysPkg::ramAddrBits-1:0]
                                            : cpuReq.dataAddr[sysPkg::ramAddrBits-1:0];
            ramPort.writeData = cpuReq.writeData;
        end
    end

    always_comb begin
        cpuResp.instruction = ramReadData;
        cpuResp.instrLoaded = running && cpuReq.instrRead && ramReady;
        if (isIo && ioCode == sysPkg::ioLoadButtons) begin
            cpuResp.readData = sysPkg::wordT'(buttons);
        end else begin
            cpuResp.readData = ramReadData;
        end
        // I/O completes in the same cycle
        cpuResp.dataLoaded = running && cpuReq.dataRead
                             && (isIo || (!cpuReq.instrRead && ramReady));
        cpuResp.dataStored = running && cpuReq.dataWrite
                             && (isIo || (!cpuReq.instrRead && ramWritten));
    end

    assign ioAccess = '{write: running && isIo && cpuReq.dataWrite,
                        code: ioCode,
                        writeData: cpuReq.writeData};

endmodule

/* verilog/buttonStretch.sv */
module buttonStretch (
    input  logic            CPUClock,
    input  logic            rstN,
    input  sysPkg::buttonsT buttonPins,
    output sysPkg::buttonsT buttons
);

    localparam int numButtons = $bits(sysPkg::buttonsT);

    sysPkg::holdCountT holdTimer [numButtons];

    // Bit stays high while its timer runs down
    always_comb begin
        for (int i = 0; i < numButtons; i++) begin
            buttons[i] = holdTimer[i] != '0;
        end
    end

    always_ff @(posedge CPUClock) begin
        if (!rstN) begin
            for (int i = 0; i < numButtons; i++) begin
                holdTimer[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numButtons; i++) begin
                if (holdTimer[i] != '0) begin
                    holdTimer[i] <= holdTimer[i] - 1'b1;
                end else if (buttonPins[i]) begin
                    // New press only taken once the previous one has run out
                    holdTimer[i] <= sysPkg::holdCountT'(sysPkg::buttonHoldCycles);
                end
            end
        end
    end

endmodule

/* verilog/ioPorts.sv */
module ioPorts (
    input  logic              CPUClock,
    input  logic              rstN,
    input  sysPkg::bootStateT bootState,
    input  sysPkg::ioAccessT  ioAccess,
    input  sysPkg::buttonsT   buttonPins,
    output sysPkg::buttonsT   buttons,
    output sysPkg::ledT       led
);

    buttonStretch u_buttonStretch (
        .CPUClock   (CPUClock),
        .rstN       (rstN),
        .buttonPins (buttonPins),
        .buttons    (buttons)
    );

    always_ff @(posedge CPUClock) begin
        if (!rstN) begin
            led <= sysPkg::ledReset;
        end else begin
            case (bootState)
                sysPkg::stReset: begin
                    led <= sysPkg::ledReset;
                end
                sysPkg::stSizeLoad: begin
                    led <= sysPkg::ledSizeLoad;
                end
                sysPkg::stSizeWait: begin
                    led <= sysPkg::ledSizeWait;
                end
                sysPkg::stRamLoad: begin
                    led <= sysPkg::ledRamLoad;
                end
                sysPkg::stLoadDone: begin
                    led <= '0;
                end
                sysPkg::stRun: begin
                    // One byte lane of the write data per code
                    if (ioAccess.write) begin
                        case (ioAccess.code)
                            sysPkg::ioWriteLeds0: led <= ioAccess.writeData[7:0];
                            sysPkg::ioWriteLeds1: led <= ioAccess.writeData[15:8];
                            sysPkg::ioWriteLeds2: led <= ioAccess.writeData[23:16];
                            sysPkg::ioWriteLeds3: led <= ioAccess.writeData[31:24];
                            default: led <= led;
                        endcase
                    end
                end
                default: begin
                    led <= sysPkg::ledReset;
                end
            endcase
        end
    end

endmodule

/* verilog/cpuSystem.sv */
module cpuSystem (
    input  logic            CPUClock,
    input  logic            rstN,
    input  logic            runButton,
    input  sysPkg::buttonsT buttonPins,
    input  sysPkg::cpuReqT  cpuReq,
    output sysPkg::cpuRespT cpuResp,
    output logic            cpuReset,
    output sysPkg::sdReqT   sdReq,
    input  sysPkg::sdRespT  sdResp,
    output sysPkg::ledT     led
);

    sysPkg::bootStateT bootState;
    sysPkg::ramPortT loadPort;
    sysPkg::ramPortT ramPort;
    sysPkg::wordT ramReadData;
    logic ramReady;
    logic ramWritten;
    sysPkg::ioAccessT ioAccess;
    sysPkg::buttonsT buttons;

    bootLoader u_bootLoader (
        .CPUClock  (CPUClock),
        .rstN      (rstN),
        .runButton (runButton),
        .sdReq     (sdReq),
        .sdResp    (sdResp),
        .loadPort  (loadPort),
        .bootState (bootState),
        .cpuReset  (cpuReset)
    );

    busRouter u_busRouter (
        .bootState   (bootState),
        .loadPort    (loadPort),
        .cpuReq      (cpuReq),
        .cpuResp     (cpuResp),
        .ramPort     (ramPort),
        .ramReadData (ramReadData),
        .ramReady    (ramReady),
        .ramWritten  (ramWritten),
        .ioAccess    (ioAccess),
        .buttons     (buttons)
    );

    wordRam u_wordRam (
        .CPUClock    (CPUClock),
        .port        (ramPort),
        .readData    (ramReadData),
        .dataReady   (ramReady),
        .dataWritten (ramWritten)
    );

    ioPorts u_ioPorts (
        .CPUClock   (CPUClock),
        .rstN       (rstN),
        .bootState  (bootState),
        .ioAccess   (ioAccess),
        .buttonPins (buttonPins),
        .buttons    (buttons),
        .led        (led)
    );

endmodule

/* bench/sdCardModel.sv */
module sdCardModel (
    input  logic           CPUClock,
    input  logic           rstN,
    input  sysPkg::sdReqT  sdReq,
    output sysPkg::sdRespT sdResp
);

    localparam int imageWords = 16;

    sysPkg::wordT image [imageWords];
    sysPkg::addrT readAddr;
    int busyLeft;

    // Busy time varies with the word address
    function automatic int busyLength(input sysPkg::addrT addr);
        return 4 + 3 * int'(addr[1:0]);
    endfunction

    // Outputs change on the falling edge, half a cycle away from the DUT's edge
    always @(negedge CPUClock) begin
        if (!rstN) begin
            sdResp.busy <= 1'b0;
            sdResp.data <= '0;
            busyLeft <= 0;
        end else if (sdReq.read) begin
            sdResp.busy <= 1'b1;
            readAddr <= sdReq.address;
            busyLeft <= busyLength(sdReq.address);
        end else if (busyLeft > 0) begin
            if (busyLeft == 1) begin
                sdResp.busy <= 1'b0;
                sdResp.data <= image[readAddr % imageWords];
            end
            busyLeft <= busyLeft - 1;
        end
    end

endmodule

/* bench/cpuSystemTb.sv */
module cpuSystemTb;

    localparam int imageLength = 5;
    localparam int timeoutCycles = 4000;

    logic CPUClock;
    logic rstN;
    logic runButton;
    sysPkg::buttonsT buttonPins;
    sysPkg::cpuReqT cpuReq;
    sysPkg::cpuRespT cpuResp;
    logic cpuReset;
    sysPkg::sdReqT sdReq;
    sysPkg::sdRespT sdResp;
    sysPkg::ledT led;

    // Word 0 is the count, words 1..N the program
    sysPkg::wordT imageData [imageLength + 1];
    logic [31:0] lcgState;
    int cycleCount = 0;

    cpuSystem u_cpuSystem (
        .CPUClock   (CPUClock),
        .rstN       (rstN),
        .runButton  (runButton),
        .buttonPins (buttonPins),
        .cpuReq     (cpuReq),
        .cpuResp    (cpuResp),
        .cpuReset   (cpuReset),
        .sdReq      (sdReq),
        .sdResp     (sdResp),
        .led        (led)
    );

    sdCardModel u_sdCardModel (
        .CPUClock (CPUClock),
        .rstN     (rstN),
        .sdReq    (sdReq),
        .sdResp   (sdResp)
    );

    always #5 CPUClock = ~CPUClock;

    always @(posedge CPUClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
            $display(">>> FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compareValue(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        if (actual !== expected) begin
            $display("FAIL at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Requests are held until their strobe is seen at a falling edge
    task automatic cpuInstrRead(input sysPkg::addrT addr, output sysPkg::wordT data);
        @(negedge CPUClock);
        cpuReq.instrRead = 1'b1;
        cpuReq.instrAddr = addr;
        do @(negedge CPUClock); while (!cpuResp.instrLoaded);
        data = cpuResp.instruction;
        cpuReq.instrRead = 1'b0;
    endtask

    task automatic cpuDataRead(input sysPkg::addrT addr, output sysPkg::wordT data);
        @(negedge CPUClock);
        cpuReq.dataRead = 1'b1;
        cpuReq.dataAddr = addr;
        do @(negedge CPUClock); while (!cpuResp.dataLoaded);
        data = cpuResp.readData;
        cpuReq.dataRead = 1'b0;
    endtask

    task automatic cpuDataWrite(input sysPkg::addrT addr, input sysPkg::wordT data);
        @(negedge CPUClock);
        cpuReq.dataWrite = 1'b1;
        cpuReq.dataAddr = addr;
        cpuReq.writeData = data;
        do @(negedge CPUClock); while (!cpuResp.dataStored);
        cpuReq.dataWrite = 1'b0;
    endtask

    task automatic holdInReset();
        repeat (100) begin
            @(negedge CPUClock);
            compareValue(cpuReset, 1'b1, "cpuReset with run button low");
            compareValue(led, sysPkg::ledReset, "led with run button low");
            compareValue(sdReq.read, 1'b0, "SD read with run button low");
        end
    endtask

    task automatic bootLoad(input string label);
        sysPkg::wordT word;
        @(negedge CPUClock);
        runButton = 1'b1;
        while (cpuReset) @(negedge CPUClock);
        compareValue(led, '0, $sformatf("led after load, %s", label));
        for (int i = 0; i < imageLength; i++) begin
            cpuInstrRead(sysPkg::addrT'(i), word);
            compareValue(word, imageData[i + 1], $sformatf("instruction %0d, %s", i, label));
        end
    endtask

    task automatic ramDataPath();
        sysPkg::wordT word;
        lcgState = lcgNext(lcgState);
        cpuDataWrite(32'h8, lcgState);
        cpuDataRead(32'h8, word);
        compareValue(word, lcgState, "RAM read back at address 8");
    endtask

    // I/O writes land on low address 2, which must keep image word 3
    task automatic ledLanes();
        sysPkg::wordT value;
        sysPkg::wordT word;
        lcgState = lcgNext(lcgState);
        value = lcgState;
        for (int k = 0; k < 4; k++) begin
            cpuDataWrite({sysPkg::ioCodeT'(sysPkg::ioWriteLeds0 + k), 24'h000002}, value);
            compareValue(led, (value >> (8 * k)) & 32'hff, $sformatf("led lane %0d", k));
        end
        cpuDataRead(32'h2, word);
        compareValue(word, imageData[3], "RAM word 2 after LED writes");
    endtask

    task automatic buttonStretchRead();
        sysPkg::wordT word;
        @(negedge CPUClock);
        buttonPins = 6'b000100;
        @(negedge CPUClock);
        buttonPins = '0;
        cpuDataRead({sysPkg::ioLoadButtons, 24'h0}, word);
        compareValue(word, 32'd1 << 2, "buttons just after press of button 3");
        repeat (sysPkg::buttonHoldCycles + 8) @(negedge CPUClock);
        cpuDataRead({sysPkg::ioLoadButtons, 24'h0}, word);
        compareValue(word, '0, "buttons after the hold time");
    endtask

    task automatic restartBoot();
        // Overwrite the program so only a fresh load can restore it
        for (int i = 0; i < imageLength; i++) begin
            cpuDataWrite(sysPkg::addrT'(i), ~imageData[i + 1]);
        end
        @(negedge CPUClock);
        runButton = 1'b0;
        repeat (3) @(negedge CPUClock);
        compareValue(cpuReset, 1'b1, "cpuReset after run button release");
        compareValue(led, sysPkg::ledReset, "led after run button release");
        bootLoad("second boot");
    endtask

    initial begin
        CPUClock = 1'b0;
        rstN = 1'b0;
        runButton = 1'b0;
        buttonPins = '0;
        cpuReq = '0;
        lcgState = 32'hdd81;
        imageData[0] = imageLength;
        for (int i = 1; i <= imageLength; i++) begin
            lcgState = lcgNext(lcgState);
            imageData[i] = lcgState;
        end
        for (int i = 0; i < 16; i++) begin
            if (i <= imageLength) begin
                u_sdCardModel.image[i] = imageData[i];
            end else begin
                u_sdCardModel.image[i] = '0;
            end
        end
        repeat (16) @(negedge CPUClock);
        rstN = 1'b1;
        holdInReset();
        bootLoad("first boot");
        ramDataPath();
        ledLanes();
        buttonStretchRead();
        restartBoot();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* project.f */
verilog/sysPkg.sv
verilog/wordRam.sv
verilog/bootLoader.sv
verilog/busRouter.sv
verilog/buttonStretch.sv
verilog/ioPorts.sv
verilog/cpuSystem.sv
bench/sdCardModel.sv
bench/cpuSystemTb.sv
